// File: core_id.f
common/core_id_pkg.sv
decode/instr_decoder.sv
decode/imm_gen.sv
verilog/reg_file.sv
verilog/id_stage_reg.sv
verilog/core_id.sv
sim/id_checker.sv
sim/id_props.sv
sim/tb_core_id.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_id
FLIST     ?= core_id.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_core_id.sv
`timescale 1ns/1ps

module tb_core_id;

  logic                    clk;
  logic                    rest;
  logic                    fd_valid;
  logic [31:0]             fd_istr;
  logic [31:0]             fd_pc;
  logic                    fd_jump;
  logic                    fd_ready;
  logic                    de_valid;
  core_id_pkg::id_bundle_t de_out;
  logic                    de_ready;
  logic                    wb_valid;
  core_id_pkg::wb_req_t    wb;
  logic                    ex_flush_en;
  logic [4:0]              em_rd;
  logic                    em_reg_write;
  logic                    em_mem_read;

  // Reference model state.
  logic [31:0]             mregs [32];
  core_id_pkg::id_bundle_t exp_q [$];
  core_id_pkg::id_bundle_t cur_exp;
  core_id_pkg::id_bundle_t exp_head;
  logic                    exp_fd_ready;
  logic                    exp_valid;
  logic                    timed_out;
  int                      accepted;
  int                      checks;
  int                      errors;

  core_id #(.NUM_REGS(32)) dut0 (
    .clk (clk), .rest (rest),
    .fd_valid (fd_valid), .fd_istr (fd_istr), .fd_pc (fd_pc), .fd_jump (fd_jump),
    .fd_ready (fd_ready), .de_valid (de_valid), .de_out (de_out), .de_ready (de_ready),
    .wb_valid (wb_valid), .wb (wb), .ex_flush_en (ex_flush_en),
    .em_rd (em_rd), .em_reg_write (em_reg_write), .em_mem_read (em_mem_read)
  );

  id_checker chk0 (
    .clk (clk), .rest (rest), .fd_ready (fd_ready), .de_valid (de_valid),
    .de_out (de_out), .exp_fd_ready (exp_fd_ready), .exp_valid (exp_valid),
    .exp_out (exp_head), .checks (checks), .errors (errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic core_id_pkg::id_ctrl_t decode_ctrl(input logic [31:0] istr);
    core_id_pkg::id_ctrl_t c;
    core_id_pkg::alu_op_e  aop;
    core_id_pkg::br_op_e   bop;
    logic [2:0]            f3;
    c = '0;
    f3 = istr[14:12];
    case (f3)
      3'd0: aop = (istr[30] && istr[6:2] == 5'b01100) ? core_id_pkg::ALU_SUB
                                                        : core_id_pkg::ALU_ADD;
      3'd1: aop = core_id_pkg::ALU_SLL;
      3'd2: aop = core_id_pkg::ALU_SLT;
      3'd3: aop = core_id_pkg::ALU_SLTU;
      3'd4: aop = core_id_pkg::ALU_XOR;
      3'd5: aop = istr[30] ? core_id_pkg::ALU_SRA : core_id_pkg::ALU_SRL;
      3'd6: aop = core_id_pkg::ALU_OR;
      default: aop = core_id_pkg::ALU_AND;
    endcase
    case (f3)
      3'd0: bop = core_id_pkg::BR_EQ;
      3'd1: bop = core_id_pkg::BR_NE;
      3'd4: bop = core_id_pkg::BR_LT;
      3'd5: bop = core_id_pkg::BR_GE;
      3'd6: bop = core_id_pkg::BR_LTU;
      default: bop = core_id_pkg::BR_GEU;
    endcase
    if (istr[1:0] != 2'b11) begin
      return '0;
    end
    case (istr[6:2])
      5'b01100: begin
        c.alu_op = aop;
        c.rs1_valid = 1'b1;
        c.rs2_valid = 1'b1;
        c.reg_write = 1'b1;
      end
      5'b00100: begin
        c.alu_op = aop;
        c.alu_in2_sel = core_id_pkg::SRC2_IMM;
        c.rs1_valid = 1'b1;
        c.reg_write = 1'b1;
      end
      5'b00000, 5'b01000: begin
        c.alu_op = core_id_pkg::ALU_ADD;
        c.alu_in2_sel = core_id_pkg::SRC2_IMM;
        c.mem_op = core_id_pkg::mem_op_e'(f3);
        c.rs1_valid = 1'b1;
        c.mem_read = !istr[5];
        c.reg_write = !istr[5];
        c.mem_write = istr[5];
        c.rs2_valid = istr[5];
      end
      5'b11000, 5'b11001, 5'b11011: begin
        c.alu_op = core_id_pkg::ALU_ADD;
        c.br_op = (istr[2] || istr[3]) ? core_id_pkg::BR_TRUE : bop;
        c.is_br = 1'b1;
        c.alu_in1_sel = (istr[6:2] == 5'b11001) ? core_id_pkg::SRC1_RS1
                                                 : core_id_pkg::SRC1_PC;
        c.alu_in2_sel = core_id_pkg::SRC2_IMM;
        c.wb_sel = core_id_pkg::WB_PC_ADD;
        c.rs1_valid = (istr[6:2] != 5'b11011);
        c.rs2_valid = (istr[6:2] == 5'b11000);
        c.reg_write = (istr[6:2] != 5'b11000);
      end
      5'b01101, 5'b00101: begin
        c.alu_op = istr[5] ? core_id_pkg::ALU_NOP : core_id_pkg::ALU_ADD;
        c.alu_in1_sel = core_id_pkg::SRC1_PC;
        c.alu_in2_sel = core_id_pkg::SRC2_IMM;
        c.wb_sel = istr[5] ? core_id_pkg::WB_IMM : core_id_pkg::WB_ALU;
        c.reg_write = 1'b1;
      end
      default: c = '0;
    endcase
    c.reg_write = c.reg_write && (istr[11:7] != 5'd0);
    return c;
  endfunction

  function automatic logic [31:0] extract_imm(input logic [31:0] istr);
    if (istr[1:0] != 2'b11) begin
      return '0;
    end
    case (istr[6:2])
      5'b00100, 5'b00000, 5'b11001: return 32'($signed(istr[31:20]));
      5'b01000: return 32'($signed({istr[31:25], istr[11:7]}));
      5'b11000: return 32'($signed({istr[31], istr[7], istr[30:25], istr[11:8], 1'b0}));
      5'b11011: return 32'($signed({istr[31], istr[19:12], istr[20], istr[30:21], 1'b0}));
      5'b01101, 5'b00101: return {istr[31:12], 12'h000};
      default: return '0;
    endcase
  endfunction

  // Mostly low registers so that hazards come up often.
  function automatic logic [31:0] rand_instr();
    logic [31:0] r;
    logic [31:0] k;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  op;
    r = $urandom;
    k = $urandom_range(10, 0);
    rd = r[31] ? r[11:7] : {2'b00, r[9:7]};
    rs1 = r[30] ? r[19:15] : {2'b00, r[17:15]};
    rs2 = r[29] ? r[24:20] : {2'b00, r[22:20]};
    f3 = r[14:12];
    f7 = r[31:25];
    op = 5'b01100;
    case (k)
      0: f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[25]) ? 7'h20 : 7'h00;
      1: begin
        op = 5'b00100;
        if (f3 == 3'd1 || f3 == 3'd5) begin
          f7 = (f3 == 3'd5 && r[25]) ? 7'h20 : 7'h00;
        end
      end
      2: begin
        op = 5'b00000;
        if (f3 == 3'd3 || f3 == 3'd6) f3 = 3'd5;
        if (f3 == 3'd7) f3 = 3'd2;
      end
      3: begin
        op = 5'b01000;
        f3 = (r[13:12] == 2'd3) ? 3'd0 : {1'b0, r[13:12]};
      end
      4: begin
        op = 5'b11000;
        if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd4;
      end
      5: begin
        op = 5'b11001;
        f3 = 3'd0;
      end
      6: return {r[31:12], rd, 5'b11011, 2'b11};
      7: return {r[31:12], rd, 5'b01101, 2'b11};
      8: return {r[31:12], rd, 5'b00101, 2'b11};
      9: begin
        case (r[1:0])
          2'd0: op = 5'b00011;
          2'd1: op = 5'b11100;
          2'd2: op = 5'b01011;
          default: op = 5'b10100;
        endcase
      end
      default: return {r[31:2], 1'b0, r[0]};
    endcase
    return {f7, rs2, rs1, f3, rd, op, 2'b11};
  endfunction

  // Builds the expectation for the current fetch inputs and the hazard verdict.
  task automatic compute_expected();
    logic hz;
    core_id_pkg::id_ctrl_t c;
    c = decode_ctrl(fd_istr);
    cur_exp.ctrl = c;
    cur_exp.pc = fd_pc;
    cur_exp.imm = extract_imm(fd_istr);
    cur_exp.rs1_value = mregs[fd_istr[19:15]];
    cur_exp.rs2_value = mregs[fd_istr[24:20]];
    cur_exp.rd = fd_istr[11:7];
    cur_exp.rs1 = fd_istr[19:15];
    cur_exp.rs2 = fd_istr[24:20];
    cur_exp.jump = fd_jump;
    hz = 1'b0;
    if (em_reg_write && em_mem_read) begin
      hz = (c.rs1_valid && cur_exp.rs1 == em_rd) || (c.rs2_valid && cur_exp.rs2 == em_rd);
    end
    if (exp_q.size() > 0 && exp_q[0].ctrl.reg_write && exp_q[0].ctrl.mem_read) begin
      hz = hz || (c.rs1_valid && cur_exp.rs1 == exp_q[0].rd) ||
           (c.rs2_valid && !c.mem_write && cur_exp.rs2 == exp_q[0].rd);
    end
    exp_valid = (exp_q.size() > 0);
    exp_head = exp_valid ? exp_q[0] : '0;
    exp_fd_ready = (!exp_valid || de_ready) && !hz && !ex_flush_en;
  endtask

  // One falling edge: account for the last rising edge, then drive new inputs.
  task automatic step(input int valid_pct, input int ready_pct, input int flush_pct,
                      input int load_pct);
    logic [31:0] r;
    if (ex_flush_en) begin
      exp_q.delete();
    end else begin
      if (exp_q.size() > 0 && de_ready) void'(exp_q.pop_front());
      if (fd_valid && exp_fd_ready) begin
        exp_q.push_back(cur_exp);
        accepted++;
      end
    end
    if (wb_valid && wb.reg_write && wb.rd != 5'd0) mregs[wb.rd] = wb.data;
    r = $urandom;
    if (!fd_valid || (exp_fd_ready && !ex_flush_en)) begin
      fd_valid = ($urandom_range(99, 0) < valid_pct);
      fd_istr = rand_instr();
      fd_pc = fd_pc + 32'd4;
      fd_jump = r[0];
    end
    de_ready = ($urandom_range(99, 0) < ready_pct);
    ex_flush_en = ($urandom_range(99, 0) < flush_pct);
    em_rd = {2'b00, r[3:1]};
    em_reg_write = ($urandom_range(99, 0) < load_pct);
    em_mem_read = em_reg_write && r[4];
    wb_valid = r[5];
    wb.rd = r[6] ? r[11:7] : {2'b00, r[9:7]};
    wb.reg_write = r[12] || r[13];
    wb.data = $urandom;
    compute_expected();
  endtask

  task automatic run_test(input string name, input int cycles, input int valid_pct,
                          input int ready_pct, input int flush_pct, input int load_pct);
    int err0;
    int acc0;
    int wait_cnt;
    err0 = errors;
    acc0 = accepted;
    if (!timed_out) begin
      repeat (cycles) begin
        @(negedge clk);
        step(valid_pct, ready_pct, flush_pct, load_pct);
      end
      wait_cnt = 0;
      while ((fd_valid || exp_q.size() > 0 || ex_flush_en) && !timed_out) begin
        if (wait_cnt == 100) begin
          $display("Timeout in %s: the output register did not drain", name);
          timed_out = 1'b1;
        end else begin
          @(negedge clk);
          step(0, 100, 0, 0);
          wait_cnt++;
        end
      end
      $display("%s: %0d accepted, %0d errors", name, accepted - acc0, errors - err0);
    end
  endtask

  initial begin
    void'($urandom(32'h650d_39d5));
    rest = 1'b0;
    fd_valid = 1'b0;
    fd_istr = '0;
    fd_pc = 32'h0000_1000;
    fd_jump = 1'b0;
    de_ready = 1'b0;
    wb_valid = 1'b0;
    wb = '0;
    ex_flush_en = 1'b0;
    em_rd = '0;
    em_reg_write = 1'b0;
    em_mem_read = 1'b0;
    timed_out = 1'b0;
    accepted = 0;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    compute_expected();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rest = 1'b1;
    run_test("decode mix", 600, 80, 90, 0, 0);
    run_test("load-use hazards", 600, 90, 70, 0, 40);
    run_test("back-pressure and flush", 600, 80, 35, 4, 20);
    $display("Summary: %0d instructions, %0d checks, %0d errors, %0d assertion failures",
             accepted, checks, errors, dut0.props0.fails);
    if (errors == 0 && dut0.props0.fails == 0 && !timed_out) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: sim/id_props.sv
`timescale 1ns/1ps

module id_props (
  input logic                    clk,
  input logic                    rest,
  input logic                    fd_ready,
  input logic                    de_valid,
  input core_id_pkg::id_bundle_t de_out,
  input logic                    de_ready,
  input logic                    ex_flush_en
);

  // Number of failed assertions.
  int fails = 0;

  // Output slot is empty coming out of reset.
  a_reset_empty: assert property (@(posedge clk) !rest |=> !de_valid)
    else begin
      $error("de_valid high after reset");
      fails++;
    end

  a_hold_stable: assert property (@(posedge clk) disable iff (!rest)
    de_valid && !de_ready |=> $stable(de_out))
    else begin
      $error("de_out changed under back-pressure");
      fails++;
    end

  a_flush_blocks: assert property (@(posedge clk) disable iff (!rest)
    ex_flush_en |-> !fd_ready)
    else begin
      $error("fd_ready high during flush");
      fails++;
    end

endmodule

bind core_id id_props props0 (
  .clk         (clk),
  .rest        (rest),
  .fd_ready    (fd_ready),
  .de_valid    (de_valid),
  .de_out      (de_out),
  .de_ready    (de_ready),
  .ex_flush_en (ex_flush_en)
);

// File: sim/id_checker.sv
`timescale 1ns/1ps

module id_checker (
  input  logic                    clk,
  input  logic                    rest,
  input  logic                    fd_ready,
  input  logic                    de_valid,
  input  core_id_pkg::id_bundle_t de_out,
  input  logic                    exp_fd_ready,
  input  logic                    exp_valid,
  input  core_id_pkg::id_bundle_t exp_out,
  output int                      checks,
  output int                      errors
);

  initial begin
    checks = 0;
    errors = 0;
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // Pre-edge values; the testbench only changes inputs on falling edges.
  always @(posedge clk) begin
    if (rest) begin
      check_value("fd_ready", 32'(exp_fd_ready), 32'(fd_ready));
      check_value("de_valid", 32'(exp_valid), 32'(de_valid));
      if (exp_valid && de_valid) begin
        check_value("de_out.ctrl", 32'(exp_out.ctrl), 32'(de_out.ctrl));
        check_value("de_out.pc", exp_out.pc, de_out.pc);
        check_value("de_out.imm", exp_out.imm, de_out.imm);
        check_value("de_out.rs1_value", exp_out.rs1_value, de_out.rs1_value);
        check_value("de_out.rs2_value", exp_out.rs2_value, de_out.rs2_value);
        // Register numbers and jump flag together.
        check_value("de_out.rd_rs1_rs2_jump",
                    32'({exp_out.rd, exp_out.rs1, exp_out.rs2, exp_out.jump}),
                    32'({de_out.rd, de_out.rs1, de_out.rs2, de_out.jump}));
      end
    end
  end

endmodule

// File: verilog/core_id.sv
`timescale 1ns/1ps

module core_id #(
  parameter int NUM_REGS = 32
) (
  input  logic                         clk,
  input  logic                         rest,
  input  logic                         fd_valid,
  input  logic [core_id_pkg::XLEN-1:0] fd_istr,
  input  logic [core_id_pkg::XLEN-1:0] fd_pc,
  input  logic                         fd_jump,
  output logic                         fd_ready,
  output logic                         de_valid,
  output core_id_pkg::id_bundle_t      de_out,
  input  logic                         de_ready,
  input  logic                         wb_valid,
  input  core_id_pkg::wb_req_t         wb,
  input  logic                         ex_flush_en,
  input  logic [4:0]                   em_rd,
  input  logic                         em_reg_write,
  input  logic                         em_mem_read
);

  core_id_pkg::id_ctrl_t        ctrl;
  logic [core_id_pkg::XLEN-1:0] imm;
  logic [core_id_pkg::XLEN-1:0] rs1_value;
  logic [core_id_pkg::XLEN-1:0] rs2_value;

  instr_decoder u_instr_decoder (
    .istr (fd_istr),
    .ctrl (ctrl)
  );

  imm_gen u_imm_gen (
    .istr (fd_istr),
    .imm  (imm)
  );

  reg_file #(
    .NUM_REGS (NUM_REGS)
  ) u_reg_file (
    .clk       (clk),
    .rest      (rest),
    .rs1       (fd_istr[19:15]),
    .rs2       (fd_istr[24:20]),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .wb_valid  (wb_valid),
    .wb        (wb)
  );

  id_stage_reg u_id_stage_reg (
    .clk          (clk),
    .rest         (rest),
    .fd_valid     (fd_valid),
    .fd_pc        (fd_pc),
    .fd_jump      (fd_jump),
    .istr         (fd_istr),
    .ctrl         (ctrl),
    .imm          (imm),
    .rs1_value    (rs1_value),
    .rs2_value    (rs2_value),
    .de_ready     (de_ready),
    .ex_flush_en  (ex_flush_en),
    .em_rd        (em_rd),
    .em_reg_write (em_reg_write),
    .em_mem_read  (em_mem_read),
    .fd_ready     (fd_ready),
    .de_valid     (de_valid),
    .de_out       (de_out)
  );

endmodule

// File: verilog/id_stage_reg.sv
`timescale 1ns/1ps

module id_stage_reg (
  input  logic                         clk,
  input  logic                         rest,
  input  logic                         fd_valid,
  input  logic [core_id_pkg::XLEN-1:0] fd_pc,
  input  logic                         fd_jump,
  input  logic [core_id_pkg::XLEN-1:0] istr,
  input  core_id_pkg::id_ctrl_t        ctrl,
  input  logic [core_id_pkg::XLEN-1:0] imm,
  input  logic [core_id_pkg::XLEN-1:0] rs1_value,
  input  logic [core_id_pkg::XLEN-1:0] rs2_value,
  input  logic                         de_ready,
  input  logic                         ex_flush_en,
  input  logic [4:0]                   em_rd,
  input  logic                         em_reg_write,
  input  logic                         em_mem_read,
  output logic                         fd_ready,
  output logic                         de_valid,
  output core_id_pkg::id_bundle_t      de_out
);

  logic [4:0] rs1;
  logic [4:0] rs2;
  logic       de_load;
  logic       em_load;
  logic       hz_de;
  logic       hz_em;
  logic       hazard;
  logic       slot_free;
  logic       accept;

  assign rs1 = istr[19:15];
  assign rs2 = istr[24:20];

  // Loads still in flight that will write a register.
  assign de_load = de_valid && de_out.ctrl.reg_write && de_out.ctrl.mem_read;
  assign em_load = em_reg_write && em_mem_read;

  // Store data from the held load is forwarded later, so rs2 of a store is exempt.
  assign hz_de = de_load &&
                 ((ctrl.rs1_valid && (rs1 == de_out.rd)) ||
                  (ctrl.rs2_valid && !ctrl.mem_write && (rs2 == de_out.rd)));
  assign hz_em = em_load &&
                 ((ctrl.rs1_valid && (rs1 == em_rd)) ||
                  (ctrl.rs2_valid && (rs2 == em_rd)));
  assign hazard = hz_de || hz_em;

  assign slot_free = !de_valid || de_ready;
  assign fd_ready  = slot_free && !hazard && !ex_flush_en;
  assign accept    = fd_valid && fd_ready;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      de_valid <= 1'b0;
    end else if (ex_flush_en) begin
      de_valid <= 1'b0;
    end else if (slot_free) begin
      de_valid <= accept;
    end
  end

  // Payload only changes on acceptance.
  always_ff @(posedge clk) begin
    if (accept) begin
      de_out.ctrl      <= ctrl;
      de_out.pc        <= fd_pc;
      de_out.imm       <= imm;
      de_out.rs1_value <= rs1_value;
      de_out.rs2_value <= rs2_value;
      de_out.rd        <= istr[11:7];
      de_out.rs1       <= rs1;
      de_out.rs2       <= rs2;
      de_out.jump      <= fd_jump;
    end
  end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic                         clk,
  input  logic                         rest,
  input  logic [4:0]                   rs1,
  input  logic [4:0]                   rs2,
  output logic [core_id_pkg::XLEN-1:0] rs1_value,
  output logic [core_id_pkg::XLEN-1:0] rs2_value,
  input  logic                         wb_valid,
  input  core_id_pkg::wb_req_t         wb
);

  localparam int AW = $clog2(NUM_REGS);

  logic [core_id_pkg::XLEN-1:0] regs [NUM_REGS];
  logic                         wr_en;

  // Out of range reads give zero on a 16 entry file.
  function automatic logic [core_id_pkg::XLEN-1:0] read_reg(input logic [4:0] addr);
    if ((addr == 5'd0) || (int'(addr) >= NUM_REGS)) begin
      return '0;
    end
    return regs[addr[AW-1:0]];
  endfunction

  assign wr_en = wb_valid && wb.reg_write && (wb.rd != 5'd0) && (int'(wb.rd) < NUM_REGS);

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd[AW-1:0]] <= wb.data;
    end
  end

  // No write bypass, a new value shows up the cycle after.
  always_comb begin
    rs1_value = read_reg(rs1);
    rs2_value = read_reg(rs2);
  end

endmodule

// File: decode/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
  input  logic [core_id_pkg::XLEN-1:0] istr,
  output logic [core_id_pkg::XLEN-1:0] imm
);

  logic [core_id_pkg::XLEN-1:0] imm_i;
  logic [core_id_pkg::XLEN-1:0] imm_s;
  logic [core_id_pkg::XLEN-1:0] imm_b;
  logic [core_id_pkg::XLEN-1:0] imm_u;
  logic [core_id_pkg::XLEN-1:0] imm_j;

  assign imm_i = {{20{istr[31]}}, istr[31:20]};
  assign imm_s = {{20{istr[31]}}, istr[31:25], istr[11:7]};
  assign imm_b = {{19{istr[31]}}, istr[31], istr[7], istr[30:25], istr[11:8], 1'b0};
  assign imm_u = {istr[31:12], 12'd0};
  assign imm_j = {{11{istr[31]}}, istr[31], istr[19:12], istr[20], istr[30:21], 1'b0};

  // Format select by major opcode.
  always_comb begin
    imm = '0;
    if (istr[1:0] == 2'b11) begin
      case (istr[6:2])
        core_id_pkg::OP_IA,
        core_id_pkg::OP_LD,
        core_id_pkg::OP_JR:    imm = imm_i;
        core_id_pkg::OP_SD:    imm = imm_s;
        core_id_pkg::OP_BR:    imm = imm_b;
        core_id_pkg::OP_J:     imm = imm_j;
        core_id_pkg::OP_LUI,
        core_id_pkg::OP_AUIPC: imm = imm_u;
        default:               imm = '0;
      endcase
    end
  end

endmodule

// File: decode/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
  input  logic [core_id_pkg::XLEN-1:0] istr,
  output core_id_pkg::id_ctrl_t        ctrl
);

  logic [4:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rd;
  logic       alt_sub;
  logic       legal;
  core_id_pkg::alu_op_e arith_op;
  core_id_pkg::br_op_e  cond_op;

  assign opcode  = istr[6:2];
  assign funct3  = istr[14:12];
  assign funct7  = istr[31:25];
  assign rd      = istr[11:7];
  // Immediate ALU has no SUB, bit 30 is part of the immediate there.
  assign alt_sub = (opcode == core_id_pkg::OP_RA) && funct7[5];

  // ALU op shared by register and immediate arithmetic.
  always_comb begin
    case (funct3)
      3'b000:  arith_op = alt_sub ? core_id_pkg::ALU_SUB : core_id_pkg::ALU_ADD;
      3'b001:  arith_op = core_id_pkg::ALU_SLL;
      3'b010:  arith_op = core_id_pkg::ALU_SLT;
      3'b011:  arith_op = core_id_pkg::ALU_SLTU;
      3'b100:  arith_op = core_id_pkg::ALU_XOR;
      3'b101:  arith_op = funct7[5] ? core_id_pkg::ALU_SRA : core_id_pkg::ALU_SRL;
      3'b110:  arith_op = core_id_pkg::ALU_OR;
      default: arith_op = core_id_pkg::ALU_AND;
    endcase
  end

  // Branch compare from funct3.
  always_comb begin
    case (funct3)
      3'b000:  cond_op = core_id_pkg::BR_EQ;
      3'b001:  cond_op = core_id_pkg::BR_NE;
      3'b100:  cond_op = core_id_pkg::BR_LT;
      3'b101:  cond_op = core_id_pkg::BR_GE;
      3'b110:  cond_op = core_id_pkg::BR_LTU;
      3'b111:  cond_op = core_id_pkg::BR_GEU;
      default: cond_op = core_id_pkg::BR_FALSE;
    endcase
  end

  always_comb begin
    ctrl  = '0;
    legal = 1'b0;
    if (istr[1:0] == 2'b11) begin
      case (opcode)
        core_id_pkg::OP_RA: begin
          legal = (funct7 == 7'h00) ||
                  ((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
          ctrl.alu_op    = arith_op;
          ctrl.rs1_valid = 1'b1;
          ctrl.rs2_valid = 1'b1;
          ctrl.reg_write = 1'b1;
        end
        core_id_pkg::OP_IA: begin
          if (funct3 == 3'b001) begin
            legal = (funct7 == 7'h00);
          end else if (funct3 == 3'b101) begin
            legal = (funct7 == 7'h00) || (funct7 == 7'h20);
          end else begin
            legal = 1'b1;
          end
          ctrl.alu_op      = arith_op;
          ctrl.alu_in2_sel = core_id_pkg::SRC2_IMM;
          ctrl.rs1_valid   = 1'b1;
          ctrl.reg_write   = 1'b1;
        end
        core_id_pkg::OP_LD: begin
          legal = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);
          ctrl.alu_op      = core_id_pkg::ALU_ADD;
          ctrl.alu_in2_sel = core_id_pkg::SRC2_IMM;
          ctrl.mem_op      = core_id_pkg::mem_op_e'(funct3);
          ctrl.mem_read    = 1'b1;
          ctrl.rs1_valid   = 1'b1;
          ctrl.reg_write   = 1'b1;
        end
        core_id_pkg::OP_SD: begin
          legal = (funct3 < 3'b011);
          ctrl.alu_op      = core_id_pkg::ALU_ADD;
          ctrl.alu_in2_sel = core_id_pkg::SRC2_IMM;
          ctrl.mem_op      = core_id_pkg::mem_op_e'(funct3);
          ctrl.mem_write   = 1'b1;
          ctrl.rs1_valid   = 1'b1;
          ctrl.rs2_valid   = 1'b1;
        end
        core_id_pkg::OP_BR: begin
          legal = (cond_op != core_id_pkg::BR_FALSE);
          ctrl.alu_op      = core_id_pkg::ALU_ADD;
          ctrl.br_op       = cond_op;
          ctrl.is_br       = 1'b1;
          ctrl.alu_in1_sel = core_id_pkg::SRC1_PC;
          ctrl.alu_in2_sel = core_id_pkg::SRC2_IMM;
          ctrl.wb_sel      = core_id_pkg::WB_PC_ADD;
          ctrl.rs1_valid   = 1'b1;
          ctrl.rs2_valid   = 1'b1;
        end
        core_id_pkg::OP_JR: begin
          legal = (funct3 == 3'b000);
          ctrl.alu_op      = core_id_pkg::ALU_ADD;
          ctrl.br_op       = core_id_pkg::BR_TRUE;
          ctrl.is_br       = 1'b1;
          ctrl.alu_in2_sel = core_id_pkg::SRC2_IMM;
          ctrl.wb_sel      = core_id_pkg::WB_PC_ADD;
          ctrl.rs1_valid   = 1'b1;
          ctrl.reg_write   = 1'b1;
        end
        core_id_pkg::OP_J: begin
          legal = 1'b1;
          ctrl.alu_op      = core_id_pkg::ALU_ADD;
          ctrl.br_op       = core_id_pkg::BR_TRUE;
          ctrl.is_br       = 1'b1;
          ctrl.alu_in1_sel = core_id_pkg::SRC1_PC;
          ctrl.alu_in2_sel = core_id_pkg::SRC2_IMM;
          ctrl.wb_sel      = core_id_pkg::WB_PC_ADD;
          ctrl.reg_write   = 1'b1;
        end
        core_id_pkg::OP_LUI: begin
          legal = 1'b1;
          ctrl.alu_in1_sel = core_id_pkg::SRC1_PC;
          ctrl.alu_in2_sel = core_id_pkg::SRC2_IMM;
          ctrl.wb_sel      = core_id_pkg::WB_IMM;
          ctrl.reg_write   = 1'b1;
        end
        core_id_pkg::OP_AUIPC: begin
          legal = 1'b1;
          ctrl.alu_op      = core_id_pkg::ALU_ADD;
          ctrl.alu_in1_sel = core_id_pkg::SRC1_PC;
          ctrl.alu_in2_sel = core_id_pkg::SRC2_IMM;
          ctrl.reg_write   = 1'b1;
        end
        default: begin
          legal = 1'b0;
        end
      endcase
    end
    // Writes to x0 are dropped here so hazards never see them.
    ctrl.reg_write = ctrl.reg_write && (rd != 5'd0);
    // Anything not recognized becomes a bubble.
    if (!legal) begin
      ctrl = '0;
    end
  end

endmodule

// File: common/core_id_pkg.sv
package core_id_pkg;

  parameter int XLEN = 32;

  // Major opcodes, instruction bits [6:2].
  typedef enum logic [4:0] {
    OP_LD    = 5'b00000,
    OP_IA    = 5'b00100,
    OP_AUIPC = 5'b00101,
    OP_SD    = 5'b01000,
    OP_RA    = 5'b01100,
    OP_LUI   = 5'b01101,
    OP_BR    = 5'b11000,
    OP_JR    = 5'b11001,
    OP_J     = 5'b11011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_NOP  = 4'd0,
    ALU_ADD  = 4'd1,
    ALU_SUB  = 4'd2,
    ALU_SLL  = 4'd3,
    ALU_SLT  = 4'd4,
    ALU_SLTU = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_SRL  = 4'd7,
    ALU_SRA  = 4'd8,
    ALU_OR   = 4'd9,
    ALU_AND  = 4'd10
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_FALSE = 4'd0,
    BR_TRUE  = 4'd1,
    BR_EQ    = 4'd2,
    BR_NE    = 4'd3,
    BR_LT    = 4'd4,
    BR_GE    = 4'd5,
    BR_LTU   = 4'd6,
    BR_GEU   = 4'd7
  } br_op_e;

  // Same values as the load/store funct3 field.
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101
  } mem_op_e;

  typedef enum logic [1:0] {
    SRC1_RS1 = 2'd0,
    SRC1_PC  = 2'd2
  } alu_src1_e;

  typedef enum logic [1:0] {
    SRC2_RS2 = 2'd0,
    SRC2_IMM = 2'd1
  } alu_src2_e;

  typedef enum logic [1:0] {
    WB_ALU    = 2'd0,
    WB_IMM    = 2'd1,
    WB_PC_ADD = 2'd3
  } wb_sel_e;

  typedef struct packed {
    alu_op_e   alu_op;
    br_op_e    br_op;
    mem_op_e   mem_op;
    logic      reg_write;
    logic      mem_write;
    logic      mem_read;
    logic      is_br;
    logic      rs1_valid;
    logic      rs2_valid;
    alu_src1_e alu_in1_sel;
    alu_src2_e alu_in2_sel;
    wb_sel_e   wb_sel;
  } id_ctrl_t;

  typedef struct packed {
    id_ctrl_t        ctrl;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_value;
    logic [XLEN-1:0] rs2_value;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic            jump;
  } id_bundle_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
    logic            reg_write;
  } wb_req_t;

endpackage
